// File: all.f
+incdir+rtl
rtl/core_isa_pkg.sv
rtl/sb_pkg.sv
rtl/sb_entries_if.sv
rtl/prio_sel.sv
rtl/sb_queue.sv
rtl/sb_clobber.sv
rtl/sb_operand_fwd.sv
rtl/scoreboard_top.sv
tests/tb_scoreboard.sv

// File: rtl/core_isa_pkg.sv
// core ISA types
// functional unit encoding and register file word types seen by the scoreboard
`default_nettype none

`include "sb_macros.svh"

package core_isa_pkg;

  // unit that will produce the result of an instruction
  typedef enum logic [2:0] {
    FU_NONE   = 3'd0,
    FU_ALU    = 3'd1,
    FU_LOAD   = 3'd2,
    FU_STORE  = 3'd3,
    FU_MULT   = 3'd4,
    FU_BRANCH = 3'd5
  } fu_t;

  // general register index
  typedef logic [`SB_REG_ADDR_W-1:0] reg_addr_t;

  // operand / result word
  typedef logic [`SB_XLEN-1:0] xlen_t;

endpackage

`default_nettype wire

// File: rtl/prio_sel.sv
// fixed-priority selector
// passes on the payload of the lowest-indexed active request and flags
// whether any request is present
`timescale 1ns/1ps
`default_nettype none

module prio_sel #(
  parameter int unsigned NumIn     = 2,
  parameter type         payload_t = logic
) (
  input  logic [NumIn-1:0] req_i,
  input  payload_t         data_i [NumIn],
  output payload_t         data_o,
  output logic             valid_o
);

  always_comb begin : sel
    data_o  = payload_t'('0);
    valid_o = 1'b0;
    // walk from the top down so the lowest index is written last
    for (int i = NumIn - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        data_o  = data_i[i];
        valid_o = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/sb_clobber.sv
// register clobber table
// for each general register, the unit of the oldest-slot in-flight
// instruction that will write it, FU_NONE when nobody does
`timescale 1ns/1ps
`default_nettype none

`include "sb_macros.svh"

module sb_clobber import core_isa_pkg::*; (
  sb_entries_if.reader                  entries,
  output fu_t [(1 << `SB_REG_ADDR_W)-1:0] rd_clobber_o
);

  localparam int unsigned NrEntries = `SB_NR_ENTRIES;
  localparam int unsigned NumRegs   = 1 << `SB_REG_ADDR_W;

  // slot units plus an always-present FU_NONE at the lowest priority
  fu_t cand_fu [NrEntries+1];

  for (genvar g = 0; g < NrEntries; g++) begin : gen_cand
    assign cand_fu[g] = entries.fu[g];
  end
  assign cand_fu[NrEntries] = FU_NONE;

  for (genvar r = 0; r < NumRegs; r++) begin : gen_reg
    logic [NrEntries:0]   req;
    logic [NrEntries-1:0] fu_match;

    // x0 is never clobbered
    for (genvar g = 0; g < NrEntries; g++) begin : gen_req
      assign req[g] = (r != 0) && entries.issued[g] && (entries.rd[g] == reg_addr_t'(r));
      assign fu_match[g] = req[g] && (entries.fu[g] == rd_clobber_o[r]);
    end
    assign req[NrEntries] = 1'b1;

    prio_sel #(
      .NumIn     (NrEntries + 1),
      .payload_t (fu_t)
    ) i_sel_clobber (
      .req_i   (req),
      .data_i  (cand_fu),
      .data_o  (rd_clobber_o[r]),
      .valid_o ()
    );

    // a unit only shows up when a slot writing this register carries it
    clobber_has_writer: assert final ((rd_clobber_o[r] == FU_NONE) || (|fu_match))
      else $error("register %0d shows a unit that no writing slot carries", r);
  end

endmodule

`default_nettype wire

// File: rtl/sb_entries_if.sv
// scoreboard entry state bundle
// exports the per-slot flags, destination, unit and result of the queue
// to the hazard and forwarding logic
`timescale 1ns/1ps
`default_nettype none

`include "sb_macros.svh"

interface sb_entries_if import core_isa_pkg::*; ();

  // one element per queue slot
  logic [`SB_NR_ENTRIES-1:0] issued;
  logic [`SB_NR_ENTRIES-1:0] valid;
  reg_addr_t                 rd     [`SB_NR_ENTRIES];
  fu_t                       fu     [`SB_NR_ENTRIES];
  xlen_t                     result [`SB_NR_ENTRIES];

  // queue side, drives the state
  modport owner (
    output issued, valid, rd, fu, result
  );

  // clobber table and operand forwarding
  modport reader (
    input issued, valid, rd, fu, result
  );

endinterface

`default_nettype wire

// File: rtl/sb_macros.svh
// scoreboard sizing
// queue depth, result width and register address width shared by
// the packages and the RTL
`ifndef SB_MACROS_SVH
`define SB_MACROS_SVH

// in-flight entries, must be a power of two
`define SB_NR_ENTRIES 8

// operand and result width
`define SB_XLEN 64

// register address width, 32 general registers
`define SB_REG_ADDR_W 5

`endif

// File: rtl/sb_operand_fwd.sv
// operand forwarding
// supplies rs1 and rs2 from the live write-back or from finished
// results still held in the queue
`timescale 1ns/1ps
`default_nettype none

`include "sb_macros.svh"

module sb_operand_fwd import core_isa_pkg::*, sb_pkg::*; (
  input  reg_addr_t           rs1_i,
  input  reg_addr_t           rs2_i,
  input  logic                wb_valid_i,
  input  trans_id_t           wb_trans_id_i,
  input  xlen_t               wb_data_i,
  sb_entries_if.reader        entries,
  output xlen_t               rs1_o,
  output xlen_t               rs2_o,
  output logic                rs1_valid_o,
  output logic                rs2_valid_o
);

  localparam int unsigned NrEntries = `SB_NR_ENTRIES;
  localparam int unsigned NumCand   = NrEntries + 1;

  // candidate 0 is the write-back bus, then the slots in index order
  xlen_t     cand_data [NumCand];
  reg_addr_t rs_addr   [2];
  xlen_t     rs_data   [2];
  logic      rs_hit    [2];
  logic      wb_live;

  // only write-backs the queue will accept are forwarded
  assign wb_live = wb_valid_i & entries.issued[wb_trans_id_i];

  assign cand_data[0] = wb_data_i;
  for (genvar g = 0; g < NrEntries; g++) begin : gen_cand
    assign cand_data[g+1] = entries.result[g];
  end

  assign rs_addr[0] = rs1_i;
  assign rs_addr[1] = rs2_i;

  for (genvar p = 0; p < 2; p++) begin : gen_port
    logic [NumCand-1:0] req;

    assign req[0] = wb_live && (entries.rd[wb_trans_id_i] == rs_addr[p]);
    for (genvar g = 0; g < NrEntries; g++) begin : gen_req
      assign req[g+1] = entries.issued[g] && entries.valid[g] && (entries.rd[g] == rs_addr[p]);
    end

    prio_sel #(
      .NumIn     (NumCand),
      .payload_t (xlen_t)
    ) i_sel_rs (
      .req_i   (req),
      .data_i  (cand_data),
      .data_o  (rs_data[p]),
      .valid_o (rs_hit[p])
    );
  end

  assign rs1_o = rs_data[0];
  assign rs2_o = rs_data[1];

  // x0 reads come from the register file
  assign rs1_valid_o = rs_hit[0] & (|rs1_i);
  assign rs2_valid_o = rs_hit[1] & (|rs2_i);

endmodule

`default_nettype wire

// File: rtl/sb_pkg.sv
// scoreboard storage types
// transaction id and the record kept per queue slot
`default_nettype none

`include "sb_macros.svh"

package sb_pkg;
  import core_isa_pkg::*;

  // queue slot index, also the tag handed to the execution units
  typedef logic [$clog2(`SB_NR_ENTRIES)-1:0] trans_id_t;

  // one slot of the in-flight queue
  typedef struct packed {
    logic      issued;  // slot holds an instruction
    logic      valid;   // result has been written back
    fu_t       fu;
    reg_addr_t rd;
    xlen_t     result;
  } sb_entry_t;

endpackage

`default_nettype wire

// File: rtl/sb_queue.sv
// scoreboard queue
// circular store of in-flight instructions, handles insert on issue,
// write-back, completion of unit-less entries, in-order commit and flush
`timescale 1ns/1ps
`default_nettype none

`include "sb_macros.svh"

module sb_queue import core_isa_pkg::*, sb_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,
  // decode side
  input  logic         decoded_valid_i,
  input  fu_t          decoded_fu_i,
  input  reg_addr_t    decoded_rd_i,
  input  logic         unresolved_branch_i,
  output logic         decoded_ack_o,
  // issue side
  input  logic         issue_ack_i,
  output logic         issue_valid_o,
  output trans_id_t    issue_trans_id_o,
  output logic         sb_full_o,
  // write-back
  input  logic         wb_valid_i,
  input  trans_id_t    wb_trans_id_i,
  input  xlen_t        wb_data_i,
  // commit
  output logic         commit_valid_o,
  output fu_t          commit_fu_o,
  output reg_addr_t    commit_rd_o,
  output xlen_t        commit_result_o,
  output trans_id_t    commit_trans_id_o,
  input  logic         commit_ack_i,
  sb_entries_if.owner  entries
);

  localparam int unsigned NrEntries = `SB_NR_ENTRIES;

  sb_entry_t mem_q [NrEntries];
  sb_entry_t mem_n [NrEntries];

  trans_id_t issue_ptr_q, issue_ptr_n;
  trans_id_t commit_ptr_q, commit_ptr_n;
  trans_id_t issue_cnt_q, issue_cnt_n;

  logic issue_full;
  logic issue_en;

  // one slot stays free, so seven usable entries
  assign issue_full = (issue_cnt_q == trans_id_t'(NrEntries - 1));
  assign sb_full_o  = issue_full;

  assign issue_valid_o    = decoded_valid_i & ~unresolved_branch_i & ~issue_full;
  assign decoded_ack_o    = issue_ack_i & ~issue_full;
  assign issue_en         = decoded_valid_i & decoded_ack_o;
  assign issue_trans_id_o = issue_ptr_q;

  // head of the queue straight from the registers
  assign commit_valid_o    = mem_q[commit_ptr_q].valid;
  assign commit_fu_o       = mem_q[commit_ptr_q].fu;
  assign commit_rd_o       = mem_q[commit_ptr_q].rd;
  assign commit_result_o   = mem_q[commit_ptr_q].result;
  assign commit_trans_id_o = commit_ptr_q;

  // ----------------------------------------------------------
  // next entry state
  // ----------------------------------------------------------
  always_comb begin : entry_next
    mem_n = mem_q;

    // insert at the issue pointer, slot is free since not full
    if (issue_en) begin
      mem_n[issue_ptr_q].issued = 1'b1;
      mem_n[issue_ptr_q].valid  = 1'b0;
      mem_n[issue_ptr_q].fu     = decoded_fu_i;
      mem_n[issue_ptr_q].rd     = decoded_rd_i;
    end

    // nothing to wait for without a unit
    for (int unsigned i = 0; i < NrEntries; i++) begin
      if (mem_q[i].issued && (mem_q[i].fu == FU_NONE)) begin
        mem_n[i].valid = 1'b1;
      end
    end

    // stale write-backs after a flush land on free slots and are dropped
    if (wb_valid_i && mem_q[wb_trans_id_i].issued) begin
      mem_n[wb_trans_id_i].valid  = 1'b1;
      mem_n[wb_trans_id_i].result = wb_data_i;
    end

    // retire the head
    if (commit_ack_i) begin
      mem_n[commit_ptr_q].issued = 1'b0;
      mem_n[commit_ptr_q].valid  = 1'b0;
    end

    if (flush_i) begin
      for (int unsigned i = 0; i < NrEntries; i++) begin
        mem_n[i].issued = 1'b0;
        mem_n[i].valid  = 1'b0;
      end
    end
  end

  // pointers and fill level
  assign issue_cnt_n  = flush_i ? '0
                      : issue_cnt_q - trans_id_t'(commit_ack_i) + trans_id_t'(issue_en);
  assign issue_ptr_n  = flush_i ? '0 : issue_ptr_q + trans_id_t'(issue_en);
  assign commit_ptr_n = flush_i ? '0 : commit_ptr_q + trans_id_t'(commit_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin : regs
    if (!rst_ni) begin
      mem_q        <= '{default: '0};
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      issue_cnt_q  <= '0;
    end else begin
      mem_q        <= mem_n;
      issue_ptr_q  <= issue_ptr_n;
      commit_ptr_q <= commit_ptr_n;
      issue_cnt_q  <= issue_cnt_n;
    end
  end

  // export slot state to the readers
  for (genvar g = 0; g < NrEntries; g++) begin : gen_entry_out
    assign entries.issued[g] = mem_q[g].issued;
    assign entries.valid[g]  = mem_q[g].valid;
    assign entries.rd[g]     = mem_q[g].rd;
    assign entries.fu[g]     = mem_q[g].fu;
    assign entries.result[g] = mem_q[g].result;
  end

  // commit stage may only retire a finished head
  commit_ack_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) commit_ack_i |-> commit_valid_o
  ) else $error("commit acknowledged without a valid head");

  // issue stage may only take what was offered
  issue_ack_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) issue_ack_i |-> issue_valid_o
  ) else $error("issue acknowledged without a valid instruction");

endmodule

`default_nettype wire

// File: rtl/scoreboard_top.sv
// instruction scoreboard
// eight-slot in-order queue with issue, write-back and commit ports,
// a general register clobber table and rs1/rs2 operand forwarding
`timescale 1ns/1ps
`default_nettype none

`include "sb_macros.svh"

module scoreboard_top import core_isa_pkg::*, sb_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  // decode / issue
  input  logic                             decoded_valid_i,
  input  fu_t                              decoded_fu_i,
  input  reg_addr_t                        decoded_rd_i,
  input  logic                             unresolved_branch_i,
  output logic                             decoded_ack_o,
  output logic                             issue_valid_o,
  input  logic                             issue_ack_i,
  output trans_id_t                        issue_trans_id_o,
  output logic                             sb_full_o,
  // write-back
  input  logic                             wb_valid_i,
  input  trans_id_t                        wb_trans_id_i,
  input  xlen_t                            wb_data_i,
  // commit
  output logic                             commit_valid_o,
  output fu_t                              commit_fu_o,
  output reg_addr_t                        commit_rd_o,
  output xlen_t                            commit_result_o,
  output trans_id_t                        commit_trans_id_o,
  input  logic                             commit_ack_i,
  // operand read
  input  reg_addr_t                        rs1_i,
  input  reg_addr_t                        rs2_i,
  output xlen_t                            rs1_o,
  output xlen_t                            rs2_o,
  output logic                             rs1_valid_o,
  output logic                             rs2_valid_o,
  // hazard info
  output fu_t [(1 << `SB_REG_ADDR_W)-1:0]  rd_clobber_o
);

  sb_entries_if i_entries ();

  sb_queue i_queue (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .decoded_valid_i     (decoded_valid_i),
    .decoded_fu_i        (decoded_fu_i),
    .decoded_rd_i        (decoded_rd_i),
    .unresolved_branch_i (unresolved_branch_i),
    .decoded_ack_o       (decoded_ack_o),
    .issue_ack_i         (issue_ack_i),
    .issue_valid_o       (issue_valid_o),
    .issue_trans_id_o    (issue_trans_id_o),
    .sb_full_o           (sb_full_o),
    .wb_valid_i          (wb_valid_i),
    .wb_trans_id_i       (wb_trans_id_i),
    .wb_data_i           (wb_data_i),
    .commit_valid_o      (commit_valid_o),
    .commit_fu_o         (commit_fu_o),
    .commit_rd_o         (commit_rd_o),
    .commit_result_o     (commit_result_o),
    .commit_trans_id_o   (commit_trans_id_o),
    .commit_ack_i        (commit_ack_i),
    .entries             (i_entries.owner)
  );

  sb_clobber i_clobber (
    .entries      (i_entries.reader),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_operand_fwd i_operand_fwd (
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .wb_valid_i    (wb_valid_i),
    .wb_trans_id_i (wb_trans_id_i),
    .wb_data_i     (wb_data_i),
    .entries       (i_entries.reader),
    .rs1_o         (rs1_o),
    .rs2_o         (rs2_o),
    .rs1_valid_o   (rs1_valid_o),
    .rs2_valid_o   (rs2_valid_o)
  );

endmodule

`default_nettype wire

// File: tests/tb_scoreboard.sv
// scoreboard testbench
// drives issue, write-back, commit, flush and operand reads into the
// scoreboard, mirrors the queue in a reference model and checks every
// output against it with concurrent assertions
`timescale 1ns/1ps
`default_nettype none

`include "sb_macros.svh"

module tb_scoreboard import core_isa_pkg::*, sb_pkg::*;;

  localparam int unsigned NrEntries     = `SB_NR_ENTRIES;
  localparam int unsigned NumRegs       = 1 << `SB_REG_ADDR_W;
  localparam int unsigned RandCycles    = 1900;
  localparam int unsigned DirCycles     = 100;
  localparam int unsigned TimeoutCycles = 2 * (RandCycles + DirCycles);
  localparam logic [31:0] LfsrSeed      = 32'h0af7_fb77;
  localparam logic [31:0] LfsrTaps      = 32'h8020_0003;

  logic clk_i, rst_ni, flush_i;
  logic decoded_valid_i, unresolved_branch_i, issue_ack_i, wb_valid_i, commit_ack_i;
  logic decoded_ack_o, issue_valid_o, sb_full_o, commit_valid_o, rs1_valid_o, rs2_valid_o;
  fu_t decoded_fu_i, commit_fu_o;
  reg_addr_t decoded_rd_i, commit_rd_o, rs1_i, rs2_i;
  trans_id_t issue_trans_id_o, wb_trans_id_i, commit_trans_id_o;
  xlen_t wb_data_i, commit_result_o, rs1_o, rs2_o;
  fu_t [NumRegs-1:0] rd_clobber_o;

  scoreboard_top uut (.*);

  // ----------------------------------------------------------
  // reference model of the queue
  // ----------------------------------------------------------
  logic [NrEntries-1:0] m_issued, m_valid;
  fu_t         m_fu     [NrEntries];
  reg_addr_t   m_rd     [NrEntries];
  xlen_t       m_result [NrEntries];
  trans_id_t   m_issue_ptr, m_commit_ptr;
  int unsigned m_cnt;
  logic        accept;
  logic [31:0] lfsr;
  int unsigned cycle_cnt = 0;

  logic exp_full, exp_issue_valid, exp_decoded_ack, exp_commit_valid;
  logic exp_rs1_valid, exp_rs2_valid;
  xlen_t exp_rs1, exp_rs2;
  fu_t [NumRegs-1:0] exp_clobber;

  // decode handshake as seen by the model
  assign accept = decoded_valid_i & issue_ack_i & ~exp_full;

  always @(posedge clk_i or negedge rst_ni) begin : model_update
    if (!rst_ni) begin
      m_issued     <= '0;
      m_valid      <= '0;
      m_issue_ptr  <= '0;
      m_commit_ptr <= '0;
      m_cnt        <= 0;
      for (int unsigned i = 0; i < NrEntries; i++) begin
        m_fu[i]     <= FU_NONE;
        m_rd[i]     <= '0;
        m_result[i] <= '0;
      end
    end else begin
      if (accept) begin
        m_issued[m_issue_ptr] <= 1'b1;
        m_valid[m_issue_ptr]  <= 1'b0;
        m_fu[m_issue_ptr]     <= decoded_fu_i;
        m_rd[m_issue_ptr]     <= decoded_rd_i;
      end
      // unit-less entries finish a cycle after they show up
      for (int unsigned i = 0; i < NrEntries; i++) begin
        if (m_issued[i] && m_fu[i] == FU_NONE) begin
          m_valid[i] <= 1'b1;
        end
      end
      if (wb_valid_i && m_issued[wb_trans_id_i]) begin
        m_valid[wb_trans_id_i]  <= 1'b1;
        m_result[wb_trans_id_i] <= wb_data_i;
      end
      if (commit_ack_i) begin
        m_issued[m_commit_ptr] <= 1'b0;
        m_valid[m_commit_ptr]  <= 1'b0;
      end
      // flush wins over everything above
      if (flush_i) begin
        m_issued     <= '0;
        m_valid      <= '0;
        m_issue_ptr  <= '0;
        m_commit_ptr <= '0;
        m_cnt        <= 0;
      end else begin
        m_issue_ptr  <= m_issue_ptr + trans_id_t'(accept);
        m_commit_ptr <= m_commit_ptr + trans_id_t'(commit_ack_i);
        m_cnt        <= m_cnt + accept - commit_ack_i;
      end
    end
  end

  // forwarded value for one read port, write-back bus first
  function automatic logic lookup_operand(input reg_addr_t rs, output xlen_t data);
    data = '0;
    if (rs == '0) begin
      return 1'b0;
    end
    if (wb_valid_i && m_issued[wb_trans_id_i] && m_rd[wb_trans_id_i] == rs) begin
      data = wb_data_i;
      return 1'b1;
    end
    for (int unsigned i = 0; i < NrEntries; i++) begin
      if (m_issued[i] && m_valid[i] && m_rd[i] == rs) begin
        data = m_result[i];
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  always_comb begin : expected
    exp_full         = (m_cnt == NrEntries - 1);
    exp_issue_valid  = decoded_valid_i && !unresolved_branch_i && !exp_full;
    exp_decoded_ack  = issue_ack_i && !exp_full;
    exp_commit_valid = m_valid[m_commit_ptr];
    exp_clobber      = '0;
    // x0 stays FU_NONE, otherwise the lowest in-flight slot writing the register
    for (int unsigned r = 1; r < NumRegs; r++) begin
      for (int i = NrEntries - 1; i >= 0; i--) begin
        if (m_issued[i] && m_rd[i] == reg_addr_t'(r)) begin
          exp_clobber[r] = m_fu[i];
        end
      end
    end
    exp_rs1_valid = lookup_operand(rs1_i, exp_rs1);
    exp_rs2_valid = lookup_operand(rs2_i, exp_rs2);
  end

  // ----------------------------------------------------------
  // failure reporting and checks
  // ----------------------------------------------------------
  task automatic stop_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    $display("[ERROR] %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    stop_with_failure();
  endtask

  issue_id_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_trans_id_o == m_issue_ptr)
    else report_mismatch("issue_trans_id_o", $sampled(issue_trans_id_o), $sampled(m_issue_ptr));
  full_chk: assert property (@(posedge clk_i) disable iff (!rst_ni) sb_full_o == exp_full)
    else report_mismatch("sb_full_o", $sampled(sb_full_o), $sampled(exp_full));
  issue_valid_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o == exp_issue_valid)
    else report_mismatch("issue_valid_o", $sampled(issue_valid_o), $sampled(exp_issue_valid));
  decoded_ack_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    decoded_ack_o == exp_decoded_ack)
    else report_mismatch("decoded_ack_o", $sampled(decoded_ack_o), $sampled(exp_decoded_ack));
  clobber_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_clobber_o == exp_clobber)
    else report_mismatch("rd_clobber_o", $sampled(rd_clobber_o), $sampled(exp_clobber));
  commit_valid_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_o == exp_commit_valid)
    else report_mismatch("commit_valid_o", $sampled(commit_valid_o),
                         $sampled(exp_commit_valid));
  // head fields only mean something while the head is finished
  commit_id_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exp_commit_valid |-> commit_trans_id_o == m_commit_ptr)
    else report_mismatch("commit_trans_id_o", $sampled(commit_trans_id_o),
                         $sampled(m_commit_ptr));
  commit_result_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exp_commit_valid |-> commit_result_o == m_result[m_commit_ptr])
    else report_mismatch("commit_result_o", $sampled(commit_result_o),
                         $sampled(m_result[m_commit_ptr]));
  commit_fu_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exp_commit_valid |-> commit_fu_o == m_fu[m_commit_ptr] && commit_rd_o == m_rd[m_commit_ptr])
    else report_mismatch("commit_fu_o/commit_rd_o", {$sampled(commit_fu_o), $sampled(commit_rd_o)},
                         {$sampled(m_fu[m_commit_ptr]), $sampled(m_rd[m_commit_ptr])});
  rs1_valid_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rs1_valid_o == exp_rs1_valid)
    else report_mismatch("rs1_valid_o", $sampled(rs1_valid_o), $sampled(exp_rs1_valid));
  rs1_chk: assert property (@(posedge clk_i) disable iff (!rst_ni) exp_rs1_valid |-> rs1_o == exp_rs1)
    else report_mismatch("rs1_o", $sampled(rs1_o), $sampled(exp_rs1));
  rs2_valid_chk: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rs2_valid_o == exp_rs2_valid)
    else report_mismatch("rs2_valid_o", $sampled(rs2_valid_o), $sampled(exp_rs2_valid));
  rs2_chk: assert property (@(posedge clk_i) disable iff (!rst_ni) exp_rs2_valid |-> rs2_o == exp_rs2)
    else report_mismatch("rs2_o", $sampled(rs2_o), $sampled(exp_rs2));

  // ----------------------------------------------------------
  // clock, watchdog and stimulus
  // ----------------------------------------------------------
  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("timeout: test sequence still running after %0d cycles", cycle_cnt);
      stop_with_failure();
    end
  end

  // galois lfsr, one step per bit handed out
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    v = '0;
    for (int unsigned k = 0; k < n; k++) begin
      v    = {v[62:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LfsrTaps) : (lfsr >> 1);
    end
    return v;
  endfunction

  // destination not used by any in-flight entry
  function automatic reg_addr_t pick_free_rd();
    reg_addr_t r;
    logic      busy;
    r = reg_addr_t'(rand_bits(5));
    for (int t = 0; t < NumRegs; t++) begin
      busy = 1'b0;
      for (int unsigned i = 0; i < NrEntries; i++) begin
        if (m_issued[i] && m_rd[i] == r) begin
          busy = 1'b1;
        end
      end
      if (!busy) begin
        return r;
      end
      r = r + 1'b1;
    end
    return r;
  endfunction

  task automatic set_idle();
    flush_i             = 1'b0;
    decoded_valid_i     = 1'b0;
    decoded_fu_i        = FU_NONE;
    decoded_rd_i        = '0;
    unresolved_branch_i = 1'b0;
    issue_ack_i         = 1'b0;
    wb_valid_i          = 1'b0;
    wb_trans_id_i       = '0;
    wb_data_i           = '0;
    commit_ack_i        = 1'b0;
    rs1_i               = '0;
    rs2_i               = '0;
  endtask

  // request held back by an open branch while there is room
  task automatic stall_on_branch();
    repeat (3) begin
      @(negedge clk_i);
      decoded_valid_i     = 1'b1;
      unresolved_branch_i = 1'b1;
      issue_ack_i         = 1'b0;
    end
  endtask

  // accept until full, then keep requesting against the full queue
  task automatic fill_queue();
    for (int k = 0; k < 12; k++) begin
      @(negedge clk_i);
      unresolved_branch_i = 1'b0;
      decoded_valid_i     = 1'b1;
      decoded_fu_i        = fu_t'(3'(k % 6));
      decoded_rd_i        = pick_free_rd();
      issue_ack_i         = (m_cnt != NrEntries - 1);
      rs1_i               = m_rd[trans_id_t'(k)];
    end
  endtask

  task automatic flush_queue();
    @(negedge clk_i);
    set_idle();
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  task automatic drive_random_cycle();
    @(negedge clk_i);
    flush_i             = (rand_bits(6) == 0);
    decoded_valid_i     = (rand_bits(1) != 0);
    unresolved_branch_i = (rand_bits(3) == 0);
    decoded_fu_i        = fu_t'(3'(rand_bits(3) % 6));
    decoded_rd_i        = pick_free_rd();
    issue_ack_i         = decoded_valid_i && !unresolved_branch_i &&
                          (m_cnt != NrEntries - 1) && (rand_bits(1) != 0);
    // write-backs may also target free slots, which must be ignored
    wb_valid_i          = (rand_bits(1) != 0);
    wb_trans_id_i       = trans_id_t'(rand_bits(3));
    wb_data_i           = xlen_t'(rand_bits(64));
    commit_ack_i        = m_valid[m_commit_ptr] && (rand_bits(2) != 0);
    rs1_i = (rand_bits(1) != 0) ? m_rd[trans_id_t'(rand_bits(3))] : reg_addr_t'(rand_bits(5));
    rs2_i = (rand_bits(1) != 0) ? m_rd[trans_id_t'(rand_bits(3))] : reg_addr_t'(rand_bits(5));
  endtask

  initial begin : stimulus
    lfsr   = LfsrSeed;
    rst_ni = 1'b0;
    set_idle();
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    stall_on_branch();
    fill_queue();
    flush_queue();
    fill_queue();
    flush_queue();
    repeat (RandCycles) drive_random_cycle();

    @(negedge clk_i);
    set_idle();
    repeat (4) @(negedge clk_i);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
